// File: project.f
+incdir+hdl
hdl/ctl_reg_pkg.sv
hdl/ctl_cfg_pkg.sv
hdl/cpu_bus_port.sv
hdl/param_poller.sv
hdl/delay_scanner.sv
hdl/cfg_commit.sv
hdl/array_ctl_top.sv
dv/clk_gen.sv
dv/array_ctl_properties.sv
dv/array_ctl_tb.sv

// File: Bender.yml
package:
  name: array_ctl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ctl_reg_pkg.sv
      - hdl/ctl_cfg_pkg.sv
      - hdl/cpu_bus_port.sv
      - hdl/param_poller.sv
      - hdl/delay_scanner.sv
      - hdl/cfg_commit.sv
      - hdl/array_ctl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/clk_gen.sv
      - dv/array_ctl_properties.sv
      - dv/array_ctl_tb.sv

// File: dv/array_ctl_tb.sv
/* Array controller testbench
   Host bus traffic for readback, status, control flags and the sync commit */

`default_nettype none

`include "array_ctl_defs.svh"

module array_ctl_tb
  import ctl_reg_pkg::*;
  import ctl_cfg_pkg::*;
();

  localparam int ACK_TIMEOUT  = 20;
  localparam int POLL_TRIES   = 10;
  localparam int FLAG_TIMEOUT = 40;
  localparam int SYNC_TIMEOUT = 60;

  logic        CLK;
  logic        rst_n;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        thermo;
  ctl_flags_t  flags;
  timing_cfg_t timing;
  logic [63:0] sync_time;
  delay_tbl_t  delays;
  logic        sync_set;

  integer             seed = 40894;
  int                 error_count = 0;
  int                 timeout_count = 0;
  logic [`DATA_W-1:0] reg_model [16]; // Last word written per register
  logic [`DATA_W-1:0] dly_model [`ARRAY_CHANNELS];

  clk_gen clk_gen_inst (.CLK(CLK), .rst_n(rst_n));

  array_ctl_top array_ctl_top_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .thermo    (thermo),
    .flags     (flags),
    .timing    (timing),
    .sync_time (sync_time),
    .delays    (delays),
    .sync_set  (sync_set)
  );

  bind array_ctl_top array_ctl_properties props_inst (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .flags      (flags),
    .sync_set   (sync_set),
    .poll_state (poller_inst.state)
  );

  task automatic finish_run();
    int assert_fails;
    assert_fails = array_ctl_top_inst.props_inst.fail_count;
    $display("Errors: %0d check, %0d assertion, %0d timeout",
             error_count, assert_fails, timeout_count);
    if (error_count + assert_fails + timeout_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    $display("Timeout: %s", what);
    timeout_count++;
  endtask

  task automatic check_value(input string test, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %0h, actual %0h", test, exp, act);
      error_count++;
    end
  endtask

  task automatic wait_ack(input logic level, input logic [7:0] addr);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (bus_rsp.ack !== level && n < ACK_TIMEOUT);
    if (bus_rsp.ack !== level) begin
      timed_out($sformatf("ack never went to %0b for address %h", level, addr));
    end
  endtask

  task automatic write_word(input logic [7:0] addr, input logic [15:0] data);
    @(posedge CLK);
    bus_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    wait_ack(1'b1, addr);
    @(posedge CLK);
    bus_req.req <= 1'b0;
    wait_ack(1'b0, addr);
    if (addr[7]) dly_model[addr[`DLY_ADDR_W-1:0]] = data;
    else reg_model[addr[3:0]] = data;
  endtask

  task automatic read_word(input logic [7:0] addr, output logic [15:0] data);
    @(posedge CLK);
    bus_req <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    wait_ack(1'b1, addr);
    data = bus_rsp.rdata; // Valid while ack is high
    @(posedge CLK);
    bus_req.req <= 1'b0;
    wait_ack(1'b0, addr);
  endtask

  task automatic poll_status(input logic level);
    logic [`DATA_W-1:0] rd;
    int n;
    n = 0;
    do begin
      read_word(8'(STATUS), rd);
      n++;
    end while (rd !== 16'(level) && n < POLL_TRIES);
    check_value("status", 16'(level), rd);
  endtask

  // Timing word assembled from the register map with the low half first
  function automatic timing_cfg_t expected_timing();
    timing_cfg_t t;
    t.mod_cycle    = reg_model[MOD_CYCLE];
    t.mod_freq_div = {reg_model[MOD_FREQ_DIV_1], reg_model[MOD_FREQ_DIV_0]};
    t.silent_step  = reg_model[SILENT_STEP];
    t.sound_speed  = {reg_model[SOUND_SPEED_1], reg_model[SOUND_SPEED_0]};
    return t;
  endfunction

  initial begin
    logic [`DATA_W-1:0] rd;
    logic [`DATA_W-1:0] ctl_val;
    ctl_flags_t         exp_flags;
    timing_cfg_t        exp_timing;
    int                 n;
    int                 pulses;
    bus_req = '0;
    thermo  = 1'b0;
    n = 0;
    while (rst_n !== 1'b1 && n < 10) begin
      @(negedge CLK);
      n++;
    end
    if (rst_n !== 1'b1) timed_out("reset was never released");
    @(negedge CLK);
    check_value("reset_flags", '0, flags);
    check_value("reset_timing", '0, timing);
    check_value("reset_sync_time", '0, sync_time);
    check_value("reset_delays", '0, delays);

    // Register and delay readback
    for (int a = MOD_CYCLE; a <= SOUND_SPEED_1; a++) write_word(8'(a), 16'($random(seed)));
    for (int a = MOD_CYCLE; a <= SOUND_SPEED_1; a++) begin
      read_word(8'(a), rd);
      check_value("readback_reg", reg_model[a], rd);
    end
    for (int c = 0; c < `ARRAY_CHANNELS; c++) write_word(8'h80 | 8'(c), 16'($random(seed)));
    for (int c = 0; c < `ARRAY_CHANNELS; c++) begin
      read_word(8'h80 | 8'(c), rd);
      check_value("readback_delay", dly_model[c], rd);
    end
    write_word(8'(VERSION), 16'($random(seed)));
    read_word(8'(VERSION), rd);
    check_value("version", `FW_VERSION, rd);

    @(posedge CLK);
    thermo <= 1'b1;
    poll_status(1'b1);
    @(posedge CLK);
    thermo <= 1'b0;
    poll_status(1'b0);

    // Control flags follow the sweep while timing waits for a sync
    ctl_val = '0;
    ctl_val[OP_MODE]   = 1'b1;
    ctl_val[FORCE_FAN] = 1'b1;
    exp_flags = '{op_mode: 1'b1, force_fan: 1'b1, legacy_mode: 1'b0};
    write_word(8'(CTL), ctl_val);
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (flags !== exp_flags && n < FLAG_TIMEOUT);
    check_value("flags", exp_flags, flags);
    check_value("flags_timing_hold", '0, timing);

    // Sync commit
    for (int a = MOD_CYCLE; a <= SOUND_SPEED_1; a++) write_word(8'(a), 16'($random(seed)));
    for (int c = 0; c < `ARRAY_CHANNELS; c++) write_word(8'h80 | 8'(c), 16'($random(seed)));
    for (int a = SYNC_TIME_0; a <= SYNC_TIME_3; a++) write_word(8'(a), 16'($random(seed)));
    exp_timing = expected_timing();
    ctl_val[SYNC] = 1'b1;
    write_word(8'(CTL), ctl_val);
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (sync_set !== 1'b1 && n < SYNC_TIMEOUT);
    if (sync_set !== 1'b1) timed_out("sync_set never pulsed after SYNC was written");
    check_value("sync_timing", exp_timing, timing);
    check_value("sync_time", {reg_model[SYNC_TIME_3], reg_model[SYNC_TIME_2],
                              reg_model[SYNC_TIME_1], reg_model[SYNC_TIME_0]}, sync_time);
    for (int c = 0; c < `ARRAY_CHANNELS; c++) check_value("sync_delay", dly_model[c], delays[c]);
    pulses = 1;
    repeat (SYNC_TIMEOUT) begin
      @(negedge CLK);
      if (sync_set) pulses++;
    end
    check_value("sync_pulse_count", 1, pulses);
    ctl_val[SYNC] = 1'b0; // Poller clears SYNC after the detour
    read_word(8'(CTL), rd);
    check_value("sync_ctl_clear", ctl_val, rd);
    finish_run();
  end

endmodule

`default_nettype wire

// File: dv/array_ctl_properties.sv
/* Bound checks on the host handshake, reset state, sync pulse and poller detour */

`default_nettype none

module array_ctl_properties
  import ctl_reg_pkg::*;
  import ctl_cfg_pkg::*;
(
  input var logic        CLK,
  input var logic        rst_n,
  input var bus_req_t    bus_req,
  input var bus_rsp_t    bus_rsp,
  input var ctl_flags_t  flags,
  input var logic        sync_set,
  input var poll_state_e poll_state
);

  int fail_count = 0;

  ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(bus_rsp.ack) |-> bus_req.req)
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  // Host drops req first, ack follows one edge later
  ack_follows_req: assert property (@(posedge CLK) disable iff (!rst_n)
    $fell(bus_req.req) |=> !bus_rsp.ack)
    else begin
      $error("ack still high one cycle after req fell");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge CLK)
    !rst_n |=> (!bus_rsp.ack && !sync_set && flags == '0))
    else begin
      $error("ack, sync_set or flags not cleared by reset");
      fail_count++;
    end

  sync_single_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    sync_set |=> !sync_set)
    else begin
      $error("sync_set held high for more than one cycle");
      fail_count++;
    end

  sync_detour_ends: assert property (@(posedge CLK) disable iff (!rst_n)
    poll_state == POLL_SYNC |-> ##[1:6] poll_state == POLL_SWEEP)
    else begin
      $error("poller stayed in the sync detour too long");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
/* Testbench clock and reset source */

`default_nettype none

module clk_gen (
  output logic CLK,
  output logic rst_n
);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK; // Period 8
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/array_ctl_top.sv
/* Array configuration controller top level */

`default_nettype none

`include "array_ctl_defs.svh"

module array_ctl_top
  import ctl_reg_pkg::*;
  import ctl_cfg_pkg::*;
(
  input  var logic        CLK,
  input  var logic        rst_n,
  input  var bus_req_t    bus_req,
  output bus_rsp_t        bus_rsp,
  input  var logic        thermo,
  output ctl_flags_t      flags,
  output timing_cfg_t     timing,
  output logic [63:0]     sync_time,
  output delay_tbl_t      delays,
  output logic            sync_set
);

  logic [`REG_ADDR_W-1:0] reg_raddr;
  logic [`DATA_W-1:0]     reg_rdata;
  logic                   reg_we;
  logic [`REG_ADDR_W-1:0] reg_waddr;
  logic [`DATA_W-1:0]     reg_wdata;
  logic [`DLY_ADDR_W-1:0] delay_raddr;
  logic [`DATA_W-1:0]     delay_rdata;
  ctl_flags_t             poll_flags;
  logic                   flags_valid;
  timing_cfg_t            poll_timing;
  logic [63:0]            poll_sync_time;
  logic                   sync_req;
  delay_tbl_t             delay_tbl;
  logic                   pass_done;

  cpu_bus_port bus_port_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .bus_req     (bus_req),
    .bus_rsp     (bus_rsp),
    .reg_raddr   (reg_raddr),
    .reg_rdata   (reg_rdata),
    .reg_we      (reg_we),
    .reg_waddr   (reg_waddr),
    .reg_wdata   (reg_wdata),
    .delay_raddr (delay_raddr),
    .delay_rdata (delay_rdata)
  );

  param_poller poller_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .thermo      (thermo),
    .reg_raddr   (reg_raddr),
    .reg_rdata   (reg_rdata),
    .reg_we      (reg_we),
    .reg_waddr   (reg_waddr),
    .reg_wdata   (reg_wdata),
    .flags       (poll_flags),
    .flags_valid (flags_valid),
    .timing      (poll_timing),
    .sync_time   (poll_sync_time),
    .sync_req    (sync_req)
  );

  delay_scanner scanner_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .delay_raddr (delay_raddr),
    .delay_rdata (delay_rdata),
    .delay_tbl   (delay_tbl),
    .pass_done   (pass_done)
  );

  cfg_commit commit_inst (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .poll_flags     (poll_flags),
    .flags_valid    (flags_valid),
    .poll_timing    (poll_timing),
    .poll_sync_time (poll_sync_time),
    .sync_req       (sync_req),
    .delay_tbl      (delay_tbl),
    .pass_done      (pass_done),
    .flags          (flags),
    .timing         (timing),
    .sync_time      (sync_time),
    .delays         (delays),
    .sync_set       (sync_set)
  );

endmodule

`default_nettype wire

// File: hdl/cfg_commit.sv
/* Output commit, control bits per sweep
   Timing, sync time and delays switch together on the first scan pass after a sync */

`default_nettype none

`include "array_ctl_defs.svh"

module cfg_commit
  import ctl_cfg_pkg::*;
(
  input  var logic        CLK,
  input  var logic        rst_n,
  input  var ctl_flags_t  poll_flags,
  input  var logic        flags_valid,
  input  var timing_cfg_t poll_timing,
  input  var logic [63:0] poll_sync_time,
  input  var logic        sync_req,
  input  var delay_tbl_t  delay_tbl,
  input  var logic        pass_done,
  output ctl_flags_t      flags,
  output timing_cfg_t     timing,
  output logic [63:0]     sync_time,
  output delay_tbl_t      delays,
  output logic            sync_set
);

  logic        sync_pending;
  timing_cfg_t pend_timing;
  logic [63:0] pend_sync_time;

  // Snapshot taken with the request
  always_ff @(posedge CLK) begin
    if (sync_req) begin
      pend_timing    <= poll_timing;
      pend_sync_time <= poll_sync_time;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      flags        <= '0;
      timing       <= '0;
      sync_time    <= '0;
      delays       <= '0;
      sync_set     <= 1'b0;
      sync_pending <= 1'b0;
    end else begin
      sync_set <= 1'b0;
      if (flags_valid) flags <= poll_flags;
      if (sync_pending && pass_done) begin
        timing       <= pend_timing;
        sync_time    <= pend_sync_time;
        delays       <= delay_tbl;
        sync_set     <= 1'b1;
        sync_pending <= 1'b0;
      end
      if (sync_req) sync_pending <= 1'b1; // A pass_done in this cycle is too early
    end
  end

endmodule

`default_nettype wire

// File: hdl/delay_scanner.sv
/* Delay scanner, copies the delay memory into a shadow table in a loop */

`default_nettype none

`include "array_ctl_defs.svh"

module delay_scanner
  import ctl_cfg_pkg::*;
(
  input  var logic                   CLK,
  input  var logic                   rst_n,
  output logic [`DLY_ADDR_W-1:0]     delay_raddr,
  input  var logic [`DATA_W-1:0]     delay_rdata,
  output delay_tbl_t                 delay_tbl,
  output logic                       pass_done
);

  localparam int CNT_W = `DLY_ADDR_W + 1;
  // One spare slot per pass separates consecutive passes
  localparam logic [CNT_W-1:0] LAST_SLOT = CNT_W'(`ARRAY_CHANNELS);

  logic [CNT_W-1:0] rd_cnt;
  logic [CNT_W-1:0] wr_cnt; // Trails rd_cnt by the read latency

  assign delay_raddr = rd_cnt[`DLY_ADDR_W-1:0];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rd_cnt    <= '0;
      wr_cnt    <= LAST_SLOT;
      pass_done <= 1'b0;
    end else begin
      rd_cnt    <= (rd_cnt == LAST_SLOT) ? '0 : rd_cnt + 1'b1;
      wr_cnt    <= rd_cnt;
      pass_done <= (wr_cnt == LAST_SLOT - 1'b1); // Last channel stored now
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_cnt != LAST_SLOT) delay_tbl[wr_cnt[`DLY_ADDR_W-1:0]] <= delay_rdata;
  end

endmodule

`default_nettype wire

// File: hdl/param_poller.sv
/* Parameter poller, sweeps the register file every 11 cycles
   On a requested sync it detours to fetch the sync time and clears the SYNC bit */

`default_nettype none

`include "array_ctl_defs.svh"

module param_poller
  import ctl_reg_pkg::*;
  import ctl_cfg_pkg::*;
(
  input  var logic                   CLK,
  input  var logic                   rst_n,
  input  var logic                   thermo,
  output logic [`REG_ADDR_W-1:0]     reg_raddr,
  input  var logic [`DATA_W-1:0]     reg_rdata,
  output logic                       reg_we,
  output logic [`REG_ADDR_W-1:0]     reg_waddr,
  output logic [`DATA_W-1:0]         reg_wdata,
  output ctl_flags_t                 flags,
  output logic                       flags_valid,
  output timing_cfg_t                timing,
  output logic [63:0]                sync_time,
  output logic                       sync_req
);

  localparam logic [3:0] SWEEP_LAST = 4'd10;
  localparam logic [3:0] SYNC_LAST  = 4'd5;

  poll_state_e        state;
  logic [3:0]         step;
  logic [`DATA_W-1:0] ctl_word;

  assign flags = '{op_mode:     ctl_word[OP_MODE],
                   force_fan:   ctl_word[FORCE_FAN],
                   legacy_mode: ctl_word[LEGACY_MODE]};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state       <= POLL_SWEEP;
      step        <= '0;
      ctl_word    <= '0;
      reg_we      <= 1'b0;
      reg_waddr   <= '0;
      reg_wdata   <= '0;
      flags_valid <= 1'b0;
      sync_req    <= 1'b0;
    end else begin
      reg_we      <= 1'b0;
      flags_valid <= 1'b0;
      sync_req    <= 1'b0;
      step        <= step + 1'b1;
      case (state)
        POLL_SWEEP: begin
          if (step == 4'd2) ctl_word <= reg_rdata; // CTL issued at step 0
          if (step == 4'd9) begin
            reg_we    <= 1'b1;
            reg_waddr <= STATUS;
            reg_wdata <= {{(`DATA_W-1){1'b0}}, thermo};
          end
          if (step == SWEEP_LAST) begin
            flags_valid <= 1'b1;
            step        <= '0;
            if (ctl_word[SYNC]) state <= POLL_SYNC;
          end
        end
        POLL_SYNC: begin
          if (step == 4'd4) begin
            reg_we          <= 1'b1;
            reg_waddr       <= CTL;
            reg_wdata       <= ctl_word;
            reg_wdata[SYNC] <= 1'b0;
          end
          if (step == SYNC_LAST) begin
            sync_req <= 1'b1; // All four words now held
            step     <= '0;
            state    <= POLL_SWEEP;
          end
        end
        default: state <= POLL_SWEEP;
      endcase
    end
  end

  // Issue one address per step, capture the word requested two steps back
  always_ff @(posedge CLK) begin
    if (state == POLL_SWEEP) begin
      case (step)
        4'd0: reg_raddr <= CTL;
        4'd1: reg_raddr <= MOD_CYCLE;
        4'd2: reg_raddr <= MOD_FREQ_DIV_0;
        4'd3: reg_raddr <= MOD_FREQ_DIV_1;
        4'd4: reg_raddr <= SILENT_STEP;
        4'd5: reg_raddr <= SOUND_SPEED_0;
        4'd6: reg_raddr <= SOUND_SPEED_1;
        default: ;
      endcase
      case (step)
        4'd3: timing.mod_cycle          <= reg_rdata;
        4'd4: timing.mod_freq_div[15:0]  <= reg_rdata;
        4'd5: timing.mod_freq_div[31:16] <= reg_rdata;
        4'd6: timing.silent_step        <= reg_rdata;
        4'd7: timing.sound_speed[15:0]   <= reg_rdata;
        4'd8: timing.sound_speed[31:16]  <= reg_rdata;
        default: ;
      endcase
    end else begin
      case (step)
        4'd0: reg_raddr <= SYNC_TIME_0;
        4'd1: reg_raddr <= SYNC_TIME_1;
        4'd2: reg_raddr <= SYNC_TIME_2;
        4'd3: reg_raddr <= SYNC_TIME_3;
        default: ;
      endcase
      if (step >= 4'd2) sync_time[(step - 4'd2)*16 +: 16] <= reg_rdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/cpu_bus_port.sv
/* Host bus slave with register file and delay memory
   Four-phase handshake on the host side, two fixed-latency read ports inside */

`default_nettype none

`include "array_ctl_defs.svh"

module cpu_bus_port
  import ctl_reg_pkg::*;
(
  input  var logic                   CLK,
  input  var logic                   rst_n,
  input  var bus_req_t               bus_req,
  output bus_rsp_t                   bus_rsp,
  input  var logic [`REG_ADDR_W-1:0] reg_raddr,
  output logic [`DATA_W-1:0]         reg_rdata,
  input  var logic                   reg_we,
  input  var logic [`REG_ADDR_W-1:0] reg_waddr,
  input  var logic [`DATA_W-1:0]     reg_wdata,
  input  var logic [`DLY_ADDR_W-1:0] delay_raddr,
  output logic [`DATA_W-1:0]         delay_rdata
);

  typedef enum logic [1:0] {IDLE, ACCESS, ACK} bus_state_e;

  bus_state_e             state;
  logic                   ack_q;
  logic [`DATA_W-1:0]     rdata_q;
  logic [`DATA_W-1:0]     reg_file [2**`REG_ADDR_W];
  logic [`DATA_W-1:0]     delay_mem [`ARRAY_CHANNELS];
  logic                   dly_sel;
  logic [`REG_ADDR_W-1:0] reg_addr;
  logic [`DLY_ADDR_W-1:0] dly_addr;
  logic                   cpu_we;
  logic                   reg_wr_ok;

  assign dly_sel   = bus_req.addr[`BUS_ADDR_W-1];
  assign reg_addr  = bus_req.addr[`REG_ADDR_W-1:0];
  assign dly_addr  = bus_req.addr[`DLY_ADDR_W-1:0];
  assign cpu_we    = (state == ACCESS) && bus_req.we; // One access per request
  assign reg_wr_ok = (reg_addr != VERSION) && (reg_addr != STATUS);

  assign bus_rsp = '{ack: ack_q, rdata: rdata_q};

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= IDLE;
      ack_q <= 1'b0;
    end else begin
      case (state)
        IDLE:   if (bus_req.req) state <= ACCESS;
        ACCESS: state <= ACK;
        ACK: begin
          if (!bus_req.req) begin
            ack_q <= 1'b0;
            state <= IDLE;
          end else begin
            ack_q <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Host write placed last so it wins a same-address collision
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**`REG_ADDR_W; i++) reg_file[i] <= '0;
    end else begin
      if (reg_we) reg_file[reg_waddr] <= reg_wdata;
      if (cpu_we && !dly_sel && reg_wr_ok) reg_file[reg_addr] <= bus_req.wdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_we && dly_sel) delay_mem[dly_addr] <= bus_req.wdata;
    reg_rdata   <= reg_file[reg_raddr];
    delay_rdata <= delay_mem[delay_raddr];
  end

  always_ff @(posedge CLK) begin
    if (state == ACCESS) begin
      if (dly_sel) rdata_q <= delay_mem[dly_addr];
      else if (reg_addr == VERSION) rdata_q <= `FW_VERSION;
      else rdata_q <= reg_file[reg_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/ctl_cfg_pkg.sv
/* Configuration types handed from the engines to the outputs */

`default_nettype none

`include "array_ctl_defs.svh"

package ctl_cfg_pkg;

  // Live control bits, refreshed every sweep
  typedef struct packed {
    logic op_mode;
    logic force_fan;
    logic legacy_mode;
  } ctl_flags_t;

  // Modulation and silencer settings applied on sync
  typedef struct packed {
    logic [15:0] mod_cycle;
    logic [31:0] mod_freq_div;
    logic [15:0] silent_step;
    logic [31:0] sound_speed;
  } timing_cfg_t;

  // One delay word per channel
  typedef logic [`ARRAY_CHANNELS-1:0][`DATA_W-1:0] delay_tbl_t;

endpackage

`default_nettype wire

// File: hdl/ctl_reg_pkg.sv
/* Register map and host bus types for the array controller */

`default_nettype none

`include "array_ctl_defs.svh"

package ctl_reg_pkg;

  typedef enum logic [`REG_ADDR_W-1:0] {
    VERSION        = 7'h00,
    CTL            = 7'h01,
    STATUS         = 7'h02, // Written by poller only
    MOD_CYCLE      = 7'h03,
    MOD_FREQ_DIV_0 = 7'h04,
    MOD_FREQ_DIV_1 = 7'h05,
    SILENT_STEP    = 7'h06,
    SOUND_SPEED_0  = 7'h07,
    SOUND_SPEED_1  = 7'h08,
    SYNC_TIME_0    = 7'h09,
    SYNC_TIME_1    = 7'h0a,
    SYNC_TIME_2    = 7'h0b,
    SYNC_TIME_3    = 7'h0c
  } reg_addr_e;

  // Bit positions inside CTL
  typedef enum logic [3:0] {
    SYNC        = 4'd0,
    OP_MODE     = 4'd1,
    FORCE_FAN   = 4'd2,
    LEGACY_MODE = 4'd3
  } ctl_bit_e;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]     wdata;
  } bus_req_t;

  typedef struct packed {
    logic               ack;
    logic [`DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef enum logic {POLL_SWEEP, POLL_SYNC} poll_state_e;

endpackage

`default_nettype wire

// File: hdl/array_ctl_defs.svh
/* Array controller sizing constants
   Channel count, bus and register address widths, word width and firmware id */

`ifndef ARRAY_CTL_DEFS_SVH
`define ARRAY_CTL_DEFS_SVH

// Transducer channels in one array
`define ARRAY_CHANNELS 8

// Register map address width
`define REG_ADDR_W 7

// Host bus address, top bit selects delay memory
`define BUS_ADDR_W 8

// Delay memory index width
`define DLY_ADDR_W $clog2(`ARRAY_CHANNELS)

`define DATA_W 16

`define FW_VERSION 16'h0103

`endif
